/* logic/keymap_cfg.svh */
// widths, table entry flag positions, prefix bytes and joystick key codes
// for the ps/2 to amiga key mapper
`ifndef KEYMAP_CFG_SVH
`define KEYMAP_CFG_SVH

`define KEYMAP_PS2_W        8      // one ps/2 byte
`define KEYMAP_AMIGA_W      8      // release bit + 7 bit key
`define KEYMAP_ENTRY_W      16     // lookup table word
`define KEYMAP_JOY_W        6

// flag bits of a table entry
`define KEYMAP_BIT_VALID    15     // real amiga key
`define KEYMAP_BIT_CTRL     14
`define KEYMAP_BIT_LALT     13
`define KEYMAP_BIT_RALT     12
`define KEYMAP_BIT_CAPS     11
`define KEYMAP_BIT_NUMLOCK  10
`define KEYMAP_BIT_KEYPAD   9
`define KEYMAP_BIT_SPECIAL  7      // prefix byte, sub-flags below
`define KEYMAP_BIT_EXT      0
`define KEYMAP_BIT_REL      1
`define KEYMAP_BIT_ACK      2

// ps/2 prefix bytes
`define KEYMAP_PS2_EXT      8'hE0
`define KEYMAP_PS2_REL      8'hF0
`define KEYMAP_PS2_ACK      8'hFA

// amiga cursor key codes used as joystick directions
`define KEYMAP_JOY_UP       7'h4C
`define KEYMAP_JOY_DOWN     7'h4D
`define KEYMAP_JOY_LEFT     7'h4F
`define KEYMAP_JOY_RIGHT    7'h4E

`endif

/* logic/keymap_pkg.sv */
// shared types of the key mapper and the joystick direction decode
`include "keymap_cfg.svh"

package keymap_pkg;

  typedef logic [`KEYMAP_PS2_W-1:0]   ps2_code_t;
  typedef logic [`KEYMAP_AMIGA_W-1:0] amiga_code_t;  // {release, key[6:0]}

  // {fire2, fire, up, down, left, right}, all low active
  typedef logic [`KEYMAP_JOY_W-1:0]   joy_t;

  // one word of the scan code lookup table
  typedef struct packed {
    logic       valid;    // bit 15
    logic       ctrl;
    logic       lalt;
    logic       ralt;
    logic       caps;
    logic       numlock;
    logic       keypad;   // bit 9
    logic       spare;    // always zero
    logic       special;  // bit 7, prefix byte
    logic [6:0] key;      // amiga key, or sub-flags of a prefix
  } key_entry_t;

  // true for the four cursor keys that double as joystick directions
  function automatic logic is_joy_dir(input logic [6:0] key);
    logic match;
    match = (key == `KEYMAP_JOY_UP) ||
            (key == `KEYMAP_JOY_DOWN) ||
            (key == `KEYMAP_JOY_LEFT) ||
            (key == `KEYMAP_JOY_RIGHT);
    return match;
  endfunction

endpackage

/* logic/key_table.sv */
// registered scan code set 2 to amiga key lookup table
`timescale 1ns/1ps
`include "keymap_cfg.svh"

module key_table import keymap_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       enable,
  input  ps2_code_t  ps2key,
  input  logic       extended,
  output key_entry_t entry,
  output logic       hit
);

  logic [`KEYMAP_ENTRY_W-1:0] rom_word;

  // index is {extended, byte}
  always_comb begin
    case ({extended, ps2key})
      9'h001: rom_word = 16'h8058;  // f9
      9'h003: rom_word = 16'h8054;  // f5
      9'h004: rom_word = 16'h8052;  // f3
      9'h005: rom_word = 16'h8050;  // f1
      9'h006: rom_word = 16'h8051;  // f2
      9'h009: rom_word = 16'h8059;  // f10
      9'h00a: rom_word = 16'h8057;  // f8
      9'h00b: rom_word = 16'h8055;  // f6
      9'h00c: rom_word = 16'h8053;  // f4
      9'h00d: rom_word = 16'h8042;  // tab
      9'h00e: rom_word = 16'h8000;  // backtick
      9'h011: rom_word = 16'ha064;  // left alt
      9'h012: rom_word = 16'h8060;  // left shift
      9'h014: rom_word = 16'hc063;  // ctrl
      9'h015: rom_word = 16'h8010;
      9'h016: rom_word = 16'h8001;
      9'h01a: rom_word = 16'h8031;
      9'h01b: rom_word = 16'h8021;
      9'h01c: rom_word = 16'h8020;  // a
      9'h01d: rom_word = 16'h8011;
      9'h01e: rom_word = 16'h8002;
      9'h021: rom_word = 16'h8033;
      9'h022: rom_word = 16'h8032;
      9'h023: rom_word = 16'h8022;
      9'h024: rom_word = 16'h8012;
      9'h025: rom_word = 16'h8004;
      9'h026: rom_word = 16'h8003;
      9'h029: rom_word = 16'h8040;  // space
      9'h02a: rom_word = 16'h8034;
      9'h02b: rom_word = 16'h8023;
      9'h02c: rom_word = 16'h8014;
      9'h02d: rom_word = 16'h8013;
      9'h02e: rom_word = 16'h8005;
      9'h031: rom_word = 16'h8036;
      9'h032: rom_word = 16'h8035;
      9'h033: rom_word = 16'h8025;
      9'h034: rom_word = 16'h8024;
      9'h035: rom_word = 16'h8015;
      9'h036: rom_word = 16'h8006;
      9'h03a: rom_word = 16'h8037;
      9'h03b: rom_word = 16'h8026;
      9'h03c: rom_word = 16'h8016;
      9'h03d: rom_word = 16'h8007;
      9'h03e: rom_word = 16'h8008;
      9'h041: rom_word = 16'h8038;
      9'h042: rom_word = 16'h8027;
      9'h043: rom_word = 16'h8017;
      9'h044: rom_word = 16'h8018;
      9'h045: rom_word = 16'h800a;
      9'h046: rom_word = 16'h8009;
      9'h049: rom_word = 16'h8039;
      9'h04a: rom_word = 16'h803a;
      9'h04b: rom_word = 16'h8028;
      9'h04c: rom_word = 16'h8029;
      9'h04d: rom_word = 16'h8019;
      9'h04e: rom_word = 16'h800b;
      9'h052: rom_word = 16'h802a;
      9'h054: rom_word = 16'h801a;
      9'h055: rom_word = 16'h800c;
      9'h058: rom_word = 16'h8862;  // caps lock
      9'h059: rom_word = 16'h8061;  // right shift
      9'h05a: rom_word = 16'h8044;  // enter
      9'h05b: rom_word = 16'h801b;
      9'h05d: rom_word = 16'h802b;  // iso key next to enter
      9'h061: rom_word = 16'h8030;  // iso key next to left shift
      9'h066: rom_word = 16'h8041;  // backspace
      9'h069: rom_word = 16'h821d;  // keypad block
      9'h06b: rom_word = 16'h822d;
      9'h06c: rom_word = 16'h823d;
      9'h070: rom_word = 16'h820f;
      9'h071: rom_word = 16'h823c;
      9'h072: rom_word = 16'h821e;
      9'h073: rom_word = 16'h822e;
      9'h074: rom_word = 16'h822f;
      9'h075: rom_word = 16'h823e;
      9'h076: rom_word = 16'h8045;  // escape
      9'h077: rom_word = 16'h0400;  // num lock, no amiga key
      9'h079: rom_word = 16'h825e;
      9'h07a: rom_word = 16'h821f;
      9'h07b: rom_word = 16'h824a;
      9'h07c: rom_word = 16'h825d;
      9'h07d: rom_word = 16'h823f;
      9'h083: rom_word = 16'h8056;  // f7
      9'h111: rom_word = 16'h9065;  // right alt
      9'h11f: rom_word = 16'h8066;  // left gui as left amiga
      9'h127: rom_word = 16'h8067;
      9'h12f: rom_word = 16'h8067;  // apps also right amiga
      9'h14a: rom_word = 16'h825c;  // keypad slash
      9'h15a: rom_word = 16'h8243;  // keypad enter
      9'h16b: rom_word = 16'h804f;  // cursor keys
      9'h170: rom_word = 16'h805f;  // insert as help
      9'h171: rom_word = 16'h8046;
      9'h172: rom_word = 16'h804d;
      9'h174: rom_word = 16'h804e;
      9'h175: rom_word = 16'h804c;
      // prefix bytes decode the same with or without a pending e0
      {1'b0, `KEYMAP_PS2_EXT}: rom_word = 16'h0081;
      {1'b1, `KEYMAP_PS2_EXT}: rom_word = 16'h0081;
      {1'b0, `KEYMAP_PS2_REL}: rom_word = 16'h0082;
      {1'b1, `KEYMAP_PS2_REL}: rom_word = 16'h0082;
      {1'b0, `KEYMAP_PS2_ACK}: rom_word = 16'h0084;
      {1'b1, `KEYMAP_PS2_ACK}: rom_word = 16'h0084;
      default: rom_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      entry <= '0;
      hit   <= 1'b0;
    end else begin
      hit <= enable;  // marks the cycle the new entry is on the output
      if (enable) begin
        entry <= key_entry_t'(rom_word);
      end
    end
  end

endmodule

/* logic/prefix_tracker.sv */
// extended and release prefix state across ps/2 bytes
`timescale 1ns/1ps
`include "keymap_cfg.svh"

module prefix_tracker import keymap_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  key_entry_t entry,
  input  logic       hit,
  output logic       extended,
  output logic       upstroke
);

  logic special;

  assign special = entry[`KEYMAP_BIT_SPECIAL];

  always_ff @(posedge clk) begin
    if (reset) begin
      extended <= 1'b0;
      upstroke <= 1'b0;
    end else if (hit) begin
      if (special) begin
        if (entry[`KEYMAP_BIT_EXT]) begin
          extended <= 1'b1;  // e0 seen
        end
        if (entry[`KEYMAP_BIT_REL]) begin
          upstroke <= 1'b1;  // f0 seen
        end
        // an ack byte keeps whatever prefix is pending
      end else begin
        // any real byte ends the prefix sequence
        extended <= 1'b0;
        upstroke <= 1'b0;
      end
    end
  end

endmodule

/* logic/amiga_key_output.sv */
// amiga key code, valid strobe, modifier flags and num lock toggle
`timescale 1ns/1ps
`include "keymap_cfg.svh"

module amiga_key_output import keymap_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  key_entry_t  entry,
  input  logic        hit,
  input  logic        upstroke,
  output logic        valid,
  output amiga_code_t akey,
  output logic        ctrl,
  output logic        aleft,
  output logic        aright,
  output logic        caps,
  output logic        numlock
);

  logic joy_key;   // key taken over by the joystick
  logic hidden;    // key kept out of the stream

  assign joy_key = is_joy_dir(entry.key) ||
                   entry[`KEYMAP_BIT_CTRL] ||
                   entry[`KEYMAP_BIT_LALT];

  // keypad and joystick keys vanish while num lock is on
  assign hidden = numlock && (entry[`KEYMAP_BIT_KEYPAD] || joy_key);

  assign valid  = hit && entry[`KEYMAP_BIT_VALID] && !hidden;
  assign akey   = {upstroke, entry.key};
  assign ctrl   = entry[`KEYMAP_BIT_CTRL] && !numlock;
  assign aleft  = entry[`KEYMAP_BIT_LALT] && !numlock;
  assign aright = entry[`KEYMAP_BIT_RALT];
  assign caps   = entry[`KEYMAP_BIT_CAPS];

  // toggles on the make code only
  always_ff @(posedge clk) begin
    if (reset) begin
      numlock <= 1'b0;
    end else if (hit && entry[`KEYMAP_BIT_NUMLOCK] && !upstroke) begin
      numlock <= !numlock;
    end
  end

endmodule

/* logic/joystick_emulator.sv */
// active low joystick lines driven by cursor, ctrl and left alt keys
`timescale 1ns/1ps
`include "keymap_cfg.svh"

module joystick_emulator import keymap_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  key_entry_t entry,
  input  logic       hit,
  input  logic       upstroke,
  input  logic       numlock,
  output joy_t       joy
);

  logic key_hit;     // real amiga key this cycle
  logic numlock_off; // num lock is being switched off
  joy_t drive;       // line owned by the key
  joy_t opposite;    // line released when the key is pressed

  assign key_hit = hit && entry[`KEYMAP_BIT_VALID];

  assign numlock_off = numlock && hit && entry[`KEYMAP_BIT_NUMLOCK] && !upstroke;

  // {fire2, fire, up, down, left, right}
  assign drive = {entry[`KEYMAP_BIT_LALT],
                  entry[`KEYMAP_BIT_CTRL],
                  entry.key == `KEYMAP_JOY_UP,
                  entry.key == `KEYMAP_JOY_DOWN,
                  entry.key == `KEYMAP_JOY_LEFT,
                  entry.key == `KEYMAP_JOY_RIGHT};

  assign opposite = {2'b00,
                     entry.key == `KEYMAP_JOY_DOWN,
                     entry.key == `KEYMAP_JOY_UP,
                     entry.key == `KEYMAP_JOY_RIGHT,
                     entry.key == `KEYMAP_JOY_LEFT};

  always_ff @(posedge clk) begin
    if (reset || !numlock || numlock_off) begin
      joy <= '1;  // idle, nothing pressed
    end else if (key_hit) begin
      for (int i = 0; i < `KEYMAP_JOY_W; i++) begin
        if (opposite[i] && !upstroke) begin
          joy[i] <= 1'b1;
        end else if (drive[i]) begin
          joy[i] <= upstroke;  // press pulls low, release lets go
        end
      end
    end
  end

endmodule

/* logic/ps2_keymap_top.sv */
// ps/2 scan code to amiga key mapper, lookup, prefix state, key output
// and joystick emulation
`timescale 1ns/1ps
`include "keymap_cfg.svh"

module ps2_keymap_top import keymap_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        enable,
  input  ps2_code_t   ps2key,
  output logic        valid,
  output amiga_code_t akey,
  output logic        ctrl,
  output logic        aleft,
  output logic        aright,
  output logic        caps,
  output logic        numlock,
  output joy_t        joy
);

  key_entry_t entry;
  logic       hit;
  logic       extended;
  logic       upstroke;

  key_table key_table_inst (
    .clk      (clk),
    .reset    (reset),
    .enable   (enable),
    .ps2key   (ps2key),
    .extended (extended),
    .entry    (entry),
    .hit      (hit)
  );

  prefix_tracker prefix_tracker_inst (
    .clk      (clk),
    .reset    (reset),
    .entry    (entry),
    .hit      (hit),
    .extended (extended),
    .upstroke (upstroke)
  );

  amiga_key_output amiga_key_output_inst (
    .clk      (clk),
    .reset    (reset),
    .entry    (entry),
    .hit      (hit),
    .upstroke (upstroke),
    .valid    (valid),
    .akey     (akey),
    .ctrl     (ctrl),
    .aleft    (aleft),
    .aright   (aright),
    .caps     (caps),
    .numlock  (numlock)
  );

  joystick_emulator joystick_emulator_inst (
    .clk      (clk),
    .reset    (reset),
    .entry    (entry),
    .hit      (hit),
    .upstroke (upstroke),
    .numlock  (numlock),
    .joy      (joy)
  );

endmodule

/* sim/keymap_tb.sv */
// directed testbench for the ps/2 to amiga key mapper
// byte driver, strobe monitor, compare tasks and six test tasks
`timescale 1ns/1ps

module keymap_tb import keymap_pkg::*; ();

  logic        clk;
  logic        reset;
  logic        enable;
  ps2_code_t   ps2key;
  logic        valid;
  amiga_code_t akey;
  logic        ctrl;
  logic        aleft;
  logic        aright;
  logic        caps;
  logic        numlock;
  joy_t        joy;

  int          valid_count;   // valid strobes seen so far
  amiga_code_t seen_akey;     // outputs captured with the last strobe
  logic        seen_ctrl;
  logic        seen_aleft;
  logic        seen_aright;
  logic        seen_caps;
  int unsigned seed_value;

  ps2_keymap_top ps2_keymap_top_inst (
    .clk     (clk),
    .reset   (reset),
    .enable  (enable),
    .ps2key  (ps2key),
    .valid   (valid),
    .akey    (akey),
    .ctrl    (ctrl),
    .aleft   (aleft),
    .aright  (aright),
    .caps    (caps),
    .numlock (numlock),
    .joy     (joy)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // outputs settle from registers well before the falling edge
  always @(negedge clk) begin
    if (valid) begin
      valid_count = valid_count + 1;
      seen_akey   = akey;
      seen_ctrl   = ctrl;
      seen_aleft  = aleft;
      seen_aright = aright;
      seen_caps   = caps;
    end
  end

  task stop_run();
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task check_code(input string name, input amiga_code_t expected, input amiga_code_t actual);
    if (actual !== expected) begin
      $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
      stop_run();
    end
  endtask

  task check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Mismatch in %s: expected %b, actual %b", name, expected, actual);
      stop_run();
    end
  endtask

  task check_joy(input string name, input joy_t expected, input joy_t actual);
    if (actual !== expected) begin
      $display("Mismatch in %s: expected %b, actual %b", name, expected, actual);
      stop_run();
    end
  endtask

  // one byte with a single enable pulse and a random idle gap after it
  task send_byte(input ps2_code_t code);
    int gap;
    gap = 3 + int'($urandom % 4);
    @(posedge clk);
    #1;
    ps2key = code;
    enable = 1'b1;
    @(posedge clk);
    #1;
    enable = 1'b0;
    repeat (gap) @(posedge clk);
    #1;
  endtask

  task wait_valid(input string name, input int start);
    int cycles;
    cycles = 0;
    while (valid_count == start) begin
      if (cycles >= 20) begin
        $display("Timeout in %s: no valid strobe within 20 cycles", name);
        stop_run();
      end
      @(negedge clk);
      cycles = cycles + 1;
    end
    if (valid_count != start + 1) begin
      $display("Error in %s: valid stayed high for more than one cycle", name);
      stop_run();
    end
  endtask

  task expect_key(input string name, input ps2_code_t code, input amiga_code_t expected);
    int start;
    start = valid_count;
    send_byte(code);
    wait_valid(name, start);
    check_code(name, expected, seen_akey);
  endtask

  // byte must not produce a valid strobe
  task expect_silent(input string name, input ps2_code_t code);
    int start;
    start = valid_count;
    send_byte(code);
    check_flag(name, 1'b0, valid_count != start);
  endtask

  task tap_numlock(input string name);
    expect_silent(name, 8'h77);
    expect_silent(name, 8'hF0);
    expect_silent(name, 8'h77);
  endtask

  task test_plain_key();
    string name;
    name = "test_plain_key";
    expect_key(name, 8'h1C, 8'h20);
    expect_silent(name, 8'hF0);     // release prefix alone
    expect_key(name, 8'h1C, 8'hA0);
  endtask

  task test_extended_key();
    string name;
    name = "test_extended_key";
    check_flag(name, 1'b0, numlock);
    expect_silent(name, 8'hE0);
    expect_key(name, 8'h75, 8'h4C);  // cursor up
    expect_silent(name, 8'hE0);
    expect_silent(name, 8'hF0);
    expect_key(name, 8'h75, 8'hCC);
  endtask

  task test_modifiers();
    string name;
    name = "test_modifiers";
    expect_key(name, 8'h14, 8'h63);
    check_flag(name, 1'b1, seen_ctrl);
    check_flag(name, 1'b0, seen_aleft);
    check_flag(name, 1'b0, seen_aright);
    expect_silent(name, 8'hF0);
    expect_key(name, 8'h14, 8'hE3);
    expect_key(name, 8'h11, 8'h64);  // left alt
    check_flag(name, 1'b1, seen_aleft);
    check_flag(name, 1'b0, seen_ctrl);
    expect_silent(name, 8'hF0);
    expect_key(name, 8'h11, 8'hE4);
    expect_key(name, 8'h58, 8'h62);  // caps lock
    check_flag(name, 1'b1, seen_caps);
    expect_silent(name, 8'hF0);
    expect_key(name, 8'h58, 8'hE2);
    expect_silent(name, 8'hE0);
    expect_key(name, 8'h11, 8'h65);  // right alt
    check_flag(name, 1'b1, seen_aright);
    check_flag(name, 1'b0, seen_aleft);
    check_flag(name, 1'b0, seen_ctrl);
    expect_silent(name, 8'hE0);
    expect_silent(name, 8'hF0);
    expect_key(name, 8'h11, 8'hE5);
  endtask

  task test_numlock();
    string name;
    name = "test_numlock";
    expect_silent(name, 8'h77);
    check_flag(name, 1'b1, numlock);
    expect_silent(name, 8'hF0);
    expect_silent(name, 8'h77);      // release keeps the state
    check_flag(name, 1'b1, numlock);
    expect_silent(name, 8'h69);      // keypad hidden
    expect_silent(name, 8'hF0);
    expect_silent(name, 8'h69);
    tap_numlock(name);
    check_flag(name, 1'b0, numlock);
    expect_key(name, 8'h69, 8'h1D);
    expect_silent(name, 8'hF0);
    expect_key(name, 8'h69, 8'h9D);
  endtask

  task test_joystick();
    string name;
    name = "test_joystick";
    tap_numlock(name);
    check_flag(name, 1'b1, numlock);
    check_joy(name, 6'b111111, joy);
    expect_silent(name, 8'hE0);
    expect_silent(name, 8'h75);      // up pressed
    check_joy(name, 6'b110111, joy);
    expect_silent(name, 8'hE0);
    expect_silent(name, 8'hF0);
    expect_silent(name, 8'h75);
    check_joy(name, 6'b111111, joy);
    expect_silent(name, 8'hE0);
    expect_silent(name, 8'h72);      // down pressed
    check_joy(name, 6'b111011, joy);
    expect_silent(name, 8'hE0);
    expect_silent(name, 8'h75);      // up takes over from down
    check_joy(name, 6'b110111, joy);
    expect_silent(name, 8'hE0);
    expect_silent(name, 8'hF0);
    expect_silent(name, 8'h75);
    check_joy(name, 6'b111111, joy);
    expect_silent(name, 8'h14);      // ctrl is fire
    check_joy(name, 6'b101111, joy);
    check_flag(name, 1'b0, ctrl);
    expect_silent(name, 8'h11);      // left alt is fire2
    check_joy(name, 6'b001111, joy);
    check_flag(name, 1'b0, aleft);
    tap_numlock(name);
    check_flag(name, 1'b0, numlock);
    check_joy(name, 6'b111111, joy);
    expect_silent(name, 8'hF0);
    expect_key(name, 8'h14, 8'hE3);
    expect_silent(name, 8'hF0);
    expect_key(name, 8'h11, 8'hE4);
  endtask

  task test_ack_passthrough();
    string name;
    name = "test_ack_passthrough";
    expect_silent(name, 8'hF0);
    expect_silent(name, 8'hFA);
    expect_key(name, 8'h1C, 8'hA0);
    expect_silent(name, 8'hE0);
    expect_silent(name, 8'hFA);      // extended survives an ack too
    expect_key(name, 8'h75, 8'h4C);
  endtask

  initial begin
    reset       = 1'b1;
    enable      = 1'b0;
    ps2key      = '0;
    valid_count = 0;
    seen_akey   = '0;
    seen_ctrl   = 1'b0;
    seen_aleft  = 1'b0;
    seen_aright = 1'b0;
    seen_caps   = 1'b0;
    seed_value  = $urandom(52);
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    check_flag("reset", 1'b0, valid);
    check_flag("reset", 1'b0, numlock);
    check_joy("reset", 6'b111111, joy);

    test_plain_key();
    test_extended_key();
    test_modifiers();
    test_numlock();
    test_joystick();
    test_ack_passthrough();

    $display("All checks passed");
    $finish;
  end

endmodule

/* compile.f */
+incdir+logic
logic/keymap_pkg.sv
logic/key_table.sv
logic/prefix_tracker.sv
logic/amiga_key_output.sv
logic/joystick_emulator.sv
logic/ps2_keymap_top.sv
sim/keymap_tb.sv

/* Makefile */
SIM := obj_dir/Vkeymap_tb

.PHONY: run clean

$(SIM): compile.f $(wildcard logic/*.sv logic/*.svh sim/*.sv)
	verilator --binary --timing --timescale 1ns/1ps --top-module keymap_tb \
		-f compile.f -o Vkeymap_tb

run: $(SIM)
	@out=$$(./$(SIM) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
